/* common/tcdm_params.svh */
////////////////////////////////////////
// TCDM bank array parameters
// Bank count, bank depth and widths
////////////////////////////////////////

`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

`define TCDM_NB_BANKS      4
`define TCDM_BANK_SIZE     256  // Words per bank
`define TCDM_DATA_WIDTH    32
`define TCDM_PARITY_WIDTH  7    // 6 Hamming bits and overall parity
`define TCDM_ADDR_WIDTH    32   // Byte address
`define TCDM_ID_WIDTH      4

`endif

/* common/tcdm_pkg.sv */
////////////////////////////////////////
// TCDM shared types
// Widths, port structs and FSM states
////////////////////////////////////////

`include "tcdm_params.svh"

package tcdm_pkg;

  typedef logic [`TCDM_DATA_WIDTH-1:0]   word_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] be_t;
  typedef logic [`TCDM_PARITY_WIDTH-1:0] parity_t;
  // Check bits sit above the data bits
  typedef logic [`TCDM_PARITY_WIDTH+`TCDM_DATA_WIDTH-1:0] codeword_t;
  typedef logic [`TCDM_ADDR_WIDTH-1:0]   tcdm_addr_t;
  typedef logic [$clog2(`TCDM_BANK_SIZE)-1:0] bank_addr_t;
  typedef logic [`TCDM_ID_WIDTH-1:0]     id_t;

  typedef struct packed {
    logic       req;
    logic       wen;   // High for a read
    tcdm_addr_t add;
    word_t      data;
    be_t        be;
    id_t        id;
  } tcdm_req_t;

  typedef struct packed {
    logic  r_valid;
    word_t r_data;
    id_t   r_id;
  } tcdm_rsp_t;

  typedef enum logic {
    IDLE,
    RMW_WRITE
  } bank_state_e;

  typedef enum logic [1:0] {
    SCRUB_IDLE,
    SCRUB_READ,
    SCRUB_FIX
  } scrub_state_e;

endpackage

/* logic/secded_codec.sv */
`timescale 1ns/100ps
////////////////////////////////////////
// SECDED Hamming(39,32) codec
// Encodes write data, corrects read data
////////////////////////////////////////

`include "tcdm_params.svh"

module secded_codec (
  input  tcdm_pkg::word_t     enc_data_i,
  output tcdm_pkg::codeword_t enc_code_o,
  input  tcdm_pkg::codeword_t dec_code_i,
  output tcdm_pkg::word_t     dec_data_o,
  output logic                dec_single_err_o,
  output logic                dec_multi_err_o
);

  import tcdm_pkg::*;

  localparam int unsigned DataWidth = `TCDM_DATA_WIDTH;
  localparam int unsigned HamBits   = `TCDM_PARITY_WIDTH - 1;
  localparam int unsigned NumPos    = DataWidth + HamBits;  // Highest Hamming position

  // Hamming position of data bit j, powers of two are check bits
  function automatic int unsigned data_pos(int unsigned j);
    int unsigned pos;
    int unsigned cnt;
    pos = 0;
    cnt = 0;
    for (int unsigned p = 3; p <= NumPos; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == j) pos = p;
        cnt++;
      end
    end
    return pos;
  endfunction

  function automatic parity_t calc_check(word_t data);
    parity_t     chk;
    int unsigned pos;
    chk = '0;
    for (int unsigned j = 0; j < DataWidth; j++) begin
      pos = data_pos(j);
      for (int unsigned b = 0; b < HamBits; b++) begin
        if (pos[b]) chk[b] = chk[b] ^ data[j];
      end
    end
    chk[HamBits] = ^{chk[HamBits-1:0], data};  // Overall parity
    return chk;
  endfunction

  word_t              raw_data;
  parity_t            raw_check;
  parity_t            recalc;
  logic [HamBits-1:0] syndrome;
  logic               parity_err;
  logic               pos_valid;

  assign enc_code_o = {calc_check(enc_data_i), enc_data_i};

  assign {raw_check, raw_data} = dec_code_i;
  assign recalc     = calc_check(raw_data);
  assign syndrome   = raw_check[HamBits-1:0] ^ recalc[HamBits-1:0];
  assign parity_err = ^dec_code_i;          // Zero for any clean codeword
  assign pos_valid  = (syndrome <= NumPos);

  // Odd flip count pointing at a real position is one flip
  assign dec_single_err_o = parity_err & pos_valid;
  assign dec_multi_err_o  = (~parity_err & (syndrome != '0)) | (parity_err & ~pos_valid);

  // Flip the data bit named by the syndrome, raw data otherwise
  always_comb begin
    dec_data_o = raw_data;
    for (int unsigned j = 0; j < DataWidth; j++) begin
      if (dec_single_err_o && (syndrome == data_pos(j))) begin
        dec_data_o[j] = ~raw_data[j];
      end
    end
  end

endmodule : secded_codec

/* ecc_bank/bank_scrubber.sv */
`timescale 1ns/100ps
////////////////////////////////////////
// ECC bank scrubber
// Walks the bank, rewrites corrected words
////////////////////////////////////////

`include "tcdm_params.svh"

module bank_scrubber (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 trigger_i,
  output logic                 scrub_req_o,
  output logic                 scrub_we_o,
  output tcdm_pkg::bank_addr_t scrub_addr_o,
  input  logic                 scrub_gnt_i,
  input  tcdm_pkg::word_t      rdata_i,
  input  logic                 single_err_i,
  input  logic                 multi_err_i,
  output tcdm_pkg::word_t      wdata_o,
  output logic                 fix_o,
  output logic                 uncorrectable_o
);

  import tcdm_pkg::*;

  scrub_state_e state_q;
  scrub_state_e state_d;
  logic         pending_q;
  bank_addr_t   addr_q;
  word_t        fix_data_q;
  logic         step_done;

  always_comb begin
    state_d   = state_q;
    step_done = 1'b0;
    unique case (state_q)
      SCRUB_IDLE: begin
        if (pending_q && scrub_gnt_i) state_d = SCRUB_READ;
      end
      SCRUB_READ: begin                     // Decoded word is on rdata_i now
        if (single_err_i) begin
          state_d = SCRUB_FIX;
        end else begin
          state_d   = SCRUB_IDLE;
          step_done = 1'b1;
        end
      end
      SCRUB_FIX: begin
        if (scrub_gnt_i) begin
          state_d   = SCRUB_IDLE;
          step_done = 1'b1;
        end
      end
      default: state_d = SCRUB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= SCRUB_IDLE;
      pending_q <= 1'b0;
      addr_q    <= '0;
    end else begin
      state_q <= state_d;
      // Triggers while waiting fold into the same step
      if (state_q == SCRUB_IDLE && scrub_gnt_i) pending_q <= 1'b0;
      else if (trigger_i) pending_q <= 1'b1;
      if (step_done) begin
        addr_q <= (addr_q == bank_addr_t'(`TCDM_BANK_SIZE - 1)) ? '0 : addr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == SCRUB_READ) fix_data_q <= rdata_i;
  end

  assign scrub_req_o     = (state_q == SCRUB_IDLE && pending_q) || (state_q == SCRUB_FIX);
  assign scrub_we_o      = (state_q == SCRUB_FIX);
  assign scrub_addr_o    = addr_q;
  assign wdata_o         = fix_data_q;
  assign fix_o           = (state_q == SCRUB_FIX) && scrub_gnt_i;
  assign uncorrectable_o = (state_q == SCRUB_READ) && multi_err_i;

  a_fix_unc_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fix_o && uncorrectable_o));

endmodule : bank_scrubber

/* ecc_bank/ecc_bank.sv */
`timescale 1ns/100ps
////////////////////////////////////////
// SECDED protected TCDM bank
// Single port with RMW and scrubbing
////////////////////////////////////////

`include "tcdm_params.svh"

module ecc_bank #(
  parameter int unsigned BankSize = `TCDM_BANK_SIZE
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::tcdm_req_t req_i,
  output logic                gnt_o,
  output tcdm_pkg::tcdm_rsp_t rsp_o,
  input  tcdm_pkg::codeword_t inject_i,
  input  logic                scrub_trigger_i,
  output logic                scrub_fix_o,
  output logic                scrub_uncorrectable_o,
  output logic                single_error_o,
  output logic                multiple_error_o
);

  import tcdm_pkg::*;

  localparam int unsigned NbBytes = $bits(be_t);
  localparam int unsigned AddrLsb = $clog2(NbBytes);

  codeword_t   mem_q [BankSize];
  bank_state_e state_q;
  bank_state_e state_d;

  bank_addr_t req_addr;
  logic       ext_gnt;
  logic       ext_partial;
  logic       scrub_req;
  logic       scrub_we;
  logic       scrub_gnt;
  bank_addr_t scrub_addr;
  word_t      scrub_wdata;
  logic       rd_en;
  bank_addr_t dec_addr;
  codeword_t  dec_code;
  word_t      dec_data;
  logic       dec_single;
  logic       dec_multi;
  word_t      enc_data;
  codeword_t  enc_code;
  logic       mem_we;
  bank_addr_t wr_addr;
  codeword_t  wr_mask;
  word_t      merged;

  logic       rsp_valid_q;
  id_t        rsp_id_q;
  word_t      rdata_q;
  logic       single_q;
  logic       multi_q;
  bank_addr_t rmw_addr_q;
  word_t      rmw_data_q;
  be_t        rmw_be_q;
  codeword_t  rmw_inject_q;

  assign req_addr    = req_i.add[AddrLsb +: $bits(bank_addr_t)];
  assign gnt_o       = (state_q == IDLE);
  assign ext_gnt     = req_i.req & gnt_o;
  assign ext_partial = ~req_i.wen & (req_i.be != '1);
  assign scrub_gnt   = scrub_req & gnt_o & ~req_i.req;  // Lowest priority
  // Reads, partial writes and scrub reads all decode the stored word
  assign rd_en       = (ext_gnt & (req_i.wen | ext_partial)) | (scrub_gnt & ~scrub_we);
  assign dec_addr    = req_i.req ? req_addr : scrub_addr;
  assign dec_code    = mem_q[dec_addr];

  assign state_d = (state_q == IDLE && ext_gnt && ext_partial) ? RMW_WRITE : IDLE;

  // New bytes over the decoded old word
  always_comb begin
    merged = rdata_q;
    for (int unsigned b = 0; b < NbBytes; b++) begin
      if (rmw_be_q[b]) merged[8*b +: 8] = rmw_data_q[8*b +: 8];
    end
  end

  always_comb begin
    mem_we   = 1'b0;
    wr_addr  = req_addr;
    wr_mask  = inject_i;
    enc_data = req_i.data;
    if (state_q == RMW_WRITE) begin
      mem_we   = 1'b1;
      wr_addr  = rmw_addr_q;
      wr_mask  = rmw_inject_q;
      enc_data = merged;
    end else if (ext_gnt) begin
      mem_we = ~req_i.wen & ~ext_partial;       // Full word write
    end else if (scrub_gnt) begin
      mem_we   = scrub_we;
      wr_addr  = scrub_addr;
      wr_mask  = '0;                            // Repairs go in clean
      enc_data = scrub_wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
      rsp_id_q    <= '0;
      single_q    <= 1'b0;
      multi_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= ext_gnt;
      single_q    <= rd_en & dec_single;
      multi_q     <= rd_en & dec_multi;
      if (ext_gnt) rsp_id_q <= req_i.id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) rdata_q <= dec_data;
    if (ext_gnt && ext_partial) begin
      rmw_addr_q   <= req_addr;
      rmw_data_q   <= req_i.data;
      rmw_be_q     <= req_i.be;
      rmw_inject_q <= inject_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_we) mem_q[wr_addr] <= enc_code ^ wr_mask;
  end

  assign rsp_o = '{r_valid: rsp_valid_q, r_data: rdata_q, r_id: rsp_id_q};

  // Flags of scrub reads stay inside the bank
  assign single_error_o   = single_q & rsp_valid_q;
  assign multiple_error_o = multi_q & rsp_valid_q;

  secded_codec i_secded_codec (
    .enc_data_i       ( enc_data   ),
    .enc_code_o       ( enc_code   ),
    .dec_code_i       ( dec_code   ),
    .dec_data_o       ( dec_data   ),
    .dec_single_err_o ( dec_single ),
    .dec_multi_err_o  ( dec_multi  )
  );

  bank_scrubber i_bank_scrubber (
    .clk_i           ( clk_i                 ),
    .rst_ni          ( rst_ni                ),
    .trigger_i       ( scrub_trigger_i       ),
    .scrub_req_o     ( scrub_req             ),
    .scrub_we_o      ( scrub_we              ),
    .scrub_addr_o    ( scrub_addr            ),
    .scrub_gnt_i     ( scrub_gnt             ),
    .rdata_i         ( rdata_q               ),
    .single_err_i    ( single_q              ),
    .multi_err_i     ( multi_q               ),
    .wdata_o         ( scrub_wdata           ),
    .fix_o           ( scrub_fix_o           ),
    .uncorrectable_o ( scrub_uncorrectable_o )
  );

  // A partial write holds off the port for exactly one cycle
  a_no_gnt_in_rmw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ext_gnt && ext_partial) |=> (!ext_gnt ##1 gnt_o));

  a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ext_gnt |=> (rsp_o.r_valid && rsp_o.r_id == $past(req_i.id)));

endmodule : ecc_bank

/* logic/tcdm_banks_wrap.sv */
`timescale 1ns/100ps
////////////////////////////////////////
// TCDM bank array top
// One SECDED bank per port
////////////////////////////////////////

`include "tcdm_params.svh"

module tcdm_banks_wrap #(
  parameter int unsigned NbBanks = `TCDM_NB_BANKS
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // TCDM ports
  input  tcdm_pkg::tcdm_req_t [NbBanks-1:0] req_i,
  output logic                [NbBanks-1:0] gnt_o,
  output tcdm_pkg::tcdm_rsp_t [NbBanks-1:0] rsp_o,
  input  tcdm_pkg::codeword_t [NbBanks-1:0] inject_i,  // XORed into written codewords
  // Scrubber
  input  logic                [NbBanks-1:0] scrub_trigger_i,
  output logic                [NbBanks-1:0] scrub_fix_o,
  output logic                [NbBanks-1:0] scrub_uncorrectable_o,
  // ECC status of port accesses
  output logic                [NbBanks-1:0] ecc_single_error_o,
  output logic                [NbBanks-1:0] ecc_multiple_error_o
);

  for (genvar i = 0; i < NbBanks; i++) begin : gen_banks
    ecc_bank #(
      .BankSize ( `TCDM_BANK_SIZE )
    ) i_ecc_bank (
      .clk_i                 ( clk_i                    ),
      .rst_ni                ( rst_ni                   ),
      .req_i                 ( req_i[i]                 ),
      .gnt_o                 ( gnt_o[i]                 ),
      .rsp_o                 ( rsp_o[i]                 ),
      .inject_i              ( inject_i[i]              ),
      .scrub_trigger_i       ( scrub_trigger_i[i]       ),
      .scrub_fix_o           ( scrub_fix_o[i]           ),
      .scrub_uncorrectable_o ( scrub_uncorrectable_o[i] ),
      .single_error_o        ( ecc_single_error_o[i]    ),
      .multiple_error_o      ( ecc_multiple_error_o[i]  )
    );
  end

endmodule : tcdm_banks_wrap

/* sim/tb_tcdm_banks_wrap.sv */
`timescale 1ns/100ps
////////////////////////////////////////
// TCDM bank array testbench
// Table driven against a memory model
////////////////////////////////////////

`include "tcdm_params.svh"

module tb_tcdm_banks_wrap;

  import tcdm_pkg::*;

  localparam int unsigned NbBanks   = `TCDM_NB_BANKS;
  localparam int unsigned BankSize  = `TCDM_BANK_SIZE;
  localparam logic [1:0]  OpRead    = 2'd0;
  localparam logic [1:0]  OpWrite   = 2'd1;
  localparam logic [1:0]  OpScrub   = 2'd2;
  localparam logic [1:0]  FlagNone  = 2'd0;
  localparam logic [1:0]  FlagSingle = 2'd1;  // Scrub fix for scrub entries
  localparam logic [1:0]  FlagMulti = 2'd2;   // Uncorrectable for scrub entries

  typedef struct packed {
    logic [7:0] bank;
    logic [1:0] op;
    bank_addr_t addr;
    be_t        be;
    word_t      data;
    codeword_t  inject;
    word_t      exp_data;
    logic [1:0] exp_flags;
    logic       chk_data;
  } entry_t;

  logic                    clk_i;
  logic                    rst_ni;
  tcdm_req_t [NbBanks-1:0] req;
  logic      [NbBanks-1:0] gnt;
  tcdm_rsp_t [NbBanks-1:0] rsp;
  codeword_t [NbBanks-1:0] inject;
  logic      [NbBanks-1:0] scrub_trigger;
  logic      [NbBanks-1:0] scrub_fix;
  logic      [NbBanks-1:0] scrub_unc;
  logic      [NbBanks-1:0] ecc_single;
  logic      [NbBanks-1:0] ecc_multi;

  entry_t      table_q [$];
  word_t       model_mem   [NbBanks][BankSize];
  int unsigned model_flips [NbBanks][BankSize];  // Injected flips per word
  bank_addr_t  scrub_ptr   [NbBanks];
  logic        table_ready;

  tcdm_banks_wrap i_tcdm_banks_wrap (
    .clk_i                 ( clk_i         ),
    .rst_ni                ( rst_ni        ),
    .req_i                 ( req           ),
    .gnt_o                 ( gnt           ),
    .rsp_o                 ( rsp           ),
    .inject_i              ( inject        ),
    .scrub_trigger_i       ( scrub_trigger ),
    .scrub_fix_o           ( scrub_fix     ),
    .scrub_uncorrectable_o ( scrub_unc     ),
    .ecc_single_error_o    ( ecc_single    ),
    .ecc_multiple_error_o  ( ecc_multi     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, act, exp));
    end
  endtask

  function automatic logic [1:0] flags_for(int unsigned flips);
    if (flips == 0) return FlagNone;
    if (flips == 1) return FlagSingle;
    return FlagMulti;
  endfunction

  task automatic add_write(int unsigned b, bank_addr_t a, be_t be, word_t data, codeword_t inj);
    entry_t e;
    e = '0;
    e.bank   = b;
    e.op     = OpWrite;
    e.addr   = a;
    e.be     = be;
    e.data   = data;
    e.inject = inj;
    // Old word flags only show up on a read-modify-write
    e.exp_flags = (be == '1) ? FlagNone : flags_for(model_flips[b][a]);
    for (int i = 0; i < $bits(be_t); i++) begin
      if (be[i]) model_mem[b][a][8*i +: 8] = data[8*i +: 8];
    end
    model_flips[b][a] = $countones(inj);
    table_q.push_back(e);
  endtask

  task automatic add_read(int unsigned b, bank_addr_t a);
    entry_t e;
    e = '0;
    e.bank      = b;
    e.op        = OpRead;
    e.addr      = a;
    e.exp_data  = model_mem[b][a];
    e.exp_flags = flags_for(model_flips[b][a]);
    e.chk_data  = (model_flips[b][a] < 2);       // Raw data on double errors
    table_q.push_back(e);
  endtask

  task automatic add_scrub(int unsigned b);
    entry_t e;
    e = '0;
    e.bank      = b;
    e.op        = OpScrub;
    e.exp_flags = flags_for(model_flips[b][scrub_ptr[b]]);
    if (model_flips[b][scrub_ptr[b]] == 1) model_flips[b][scrub_ptr[b]] = 0;
    scrub_ptr[b] = scrub_ptr[b] + 1'b1;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    for (int b = 0; b < NbBanks; b++) scrub_ptr[b] = '0;
    for (int b = 0; b < NbBanks; b++) begin
      for (int a = 0; a < BankSize; a++) add_write(b, a, 4'hf, $urandom(), '0);
    end
    for (int b = 0; b < NbBanks; b++) begin
      for (int a = 0; a < BankSize; a++) add_read(b, a);
    end
    for (int be = 0; be < 15; be++) begin
      add_write(1, bank_addr_t'(16 + be), be_t'(be), $urandom(), '0);
      add_read(1, bank_addr_t'(16 + be));
    end
    // Data bit flip, check bit flip, then two flips
    add_write(2, 5, 4'hf, 32'hcafe_f00d, codeword_t'(1) << 3);
    add_read(2, 5);
    add_write(2, 6, 4'hf, 32'h1234_5678, codeword_t'(1) << 35);
    add_read(2, 6);
    add_write(2, 7, 4'hf, 32'h0bad_beef, (codeword_t'(1) << 9) | codeword_t'(1));
    add_read(2, 7);
    add_write(2, 6, 4'b0011, 32'h5555_aaaa, '0);  // RMW over a corrected word
    add_read(2, 6);
    // Scrub targets: word 0 one flip, word 1 two flips
    add_write(3, 0, 4'hf, $urandom(), codeword_t'(1) << 12);
    add_write(3, 1, 4'hf, $urandom(), codeword_t'(3) << 20);
    add_scrub(3);
    add_read(3, 0);
    add_scrub(3);
    add_scrub(3);
  endtask

  task automatic run_access(entry_t e, int unsigned idx);
    tcdm_req_t          r;
    logic [NbBanks-1:0] bank_bit;
    logic [NbBanks-1:0] gnt_exp;
    r.req    = 1'b1;
    r.wen    = (e.op == OpRead);
    r.add    = tcdm_addr_t'(e.addr) << 2;
    r.data   = e.data;
    r.be     = (e.op == OpRead) ? '0 : e.be;
    r.id     = id_t'(idx);
    bank_bit = 1 << e.bank;
    gnt_exp  = {NbBanks{1'b1}};
    if (e.op == OpWrite && e.be != '1) gnt_exp[e.bank] = 1'b0;
    @(posedge clk_i);
    req[e.bank]    <= r;
    inject[e.bank] <= e.inject;
    @(negedge clk_i);
    while (!gnt[e.bank]) @(negedge clk_i);
    @(posedge clk_i);
    req[e.bank].req <= 1'b0;
    inject[e.bank]  <= '0;
    @(negedge clk_i);
    check_value("r_valid", rsp[e.bank].r_valid, 1'b1);
    check_value("r_id", rsp[e.bank].r_id, id_t'(idx));
    check_value("ecc_single_error_o", ecc_single, (e.exp_flags == FlagSingle) ? bank_bit : '0);
    check_value("ecc_multiple_error_o", ecc_multi, (e.exp_flags == FlagMulti) ? bank_bit : '0);
    check_value("gnt_o", gnt, gnt_exp);
    if (e.chk_data) check_value("r_data", rsp[e.bank].r_data, e.exp_data);
    @(negedge clk_i);
    check_value("r_valid", rsp[e.bank].r_valid, 1'b0);
    check_value("gnt_o", gnt, {NbBanks{1'b1}});
  endtask

  task automatic run_scrub(entry_t e);
    logic        seen_fix;
    logic        seen_unc;
    int unsigned cycles;
    @(posedge clk_i);
    scrub_trigger[e.bank] <= 1'b1;
    @(posedge clk_i);
    scrub_trigger[e.bank] <= 1'b0;
    seen_fix = 1'b0;
    seen_unc = 1'b0;
    cycles   = 0;
    // Clean words end the step without any pulse
    while (!seen_fix && !seen_unc && cycles < 10) begin
      @(negedge clk_i);
      seen_fix = scrub_fix[e.bank];
      seen_unc = scrub_unc[e.bank];
      check_value("ecc_single_error_o", ecc_single, '0);
      check_value("ecc_multiple_error_o", ecc_multi, '0);
      cycles++;
    end
    check_value("scrub_fix_o", seen_fix, e.exp_flags == FlagSingle);
    check_value("scrub_uncorrectable_o", seen_unc, e.exp_flags == FlagMulti);
  endtask

  initial begin
    wait (table_ready);
    repeat (table_q.size() * 20) @(posedge clk_i);
    fail_run("Watchdog expired before all table entries completed");
  end

  initial begin
    table_ready   = 1'b0;
    rst_ni        = 1'b0;
    req           = '0;
    inject        = '0;
    scrub_trigger = '0;
    void'($urandom(32'hf912_6051));
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    for (int b = 0; b < NbBanks; b++) check_value("r_valid", rsp[b].r_valid, 1'b0);
    check_value("scrub_fix_o", scrub_fix, '0);
    check_value("scrub_uncorrectable_o", scrub_unc, '0);
    check_value("ecc_single_error_o", ecc_single, '0);
    check_value("ecc_multiple_error_o", ecc_multi, '0);
    check_value("gnt_o", gnt, {NbBanks{1'b1}});
    foreach (table_q[i]) begin
      if (table_q[i].op == OpScrub) run_scrub(table_q[i]);
      else run_access(table_q[i], i);
    end
    $display("Test passed");
    $finish;
  end

endmodule : tb_tcdm_banks_wrap

/* tcdm_ecc_banks.f */
+incdir+common
common/tcdm_pkg.sv
logic/secded_codec.sv
ecc_bank/bank_scrubber.sv
ecc_bank/ecc_bank.sv
logic/tcdm_banks_wrap.sv
sim/tb_tcdm_banks_wrap.sv

/* Bender.yml */
package:
  name: tcdm_ecc_banks

export_include_dirs:
  - common

sources:
  - common/tcdm_pkg.sv
  - logic/secded_codec.sv
  - ecc_bank/bank_scrubber.sv
  - ecc_bank/ecc_bank.sv
  - logic/tcdm_banks_wrap.sv
  - target: test
    files:
      - sim/tb_tcdm_banks_wrap.sv
